// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = DATA_W / 8;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;  // byte offset in a line
    localparam int BEAT_W         = 3;  // word index in a line

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL,
        FILL_DONE
    } ctrl_state_e;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } cpu_op_e;

endpackage

`default_nettype wire

// ==== hdl/dcache_xfer_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_xfer_counter #(
    parameter int RD_CREDITS = 1,
    parameter int WR_CREDITS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          xfer_start_i,
    input  logic                          beat_advance_i,  // refill beat received
    input  logic                          rd_take_i,
    input  logic                          rd_credit_i,
    input  logic                          wr_take_i,       // write-back beat sent
    input  logic                          wr_credit_i,
    output logic [dcache_pkg::BEAT_W-1:0] beat_o,
    output logic                          last_beat_o,
    output logic                          rd_credit_ok_o,
    output logic                          wr_credit_ok_o
);
    import dcache_pkg::*;

    localparam int RD_CW = $clog2(RD_CREDITS + 1);
    localparam int WR_CW = $clog2(WR_CREDITS + 1);

    logic [RD_CW-1:0] rd_cnt;
    logic [WR_CW-1:0] wr_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_o <= '0;
            rd_cnt <= RD_CW'(RD_CREDITS);
            wr_cnt <= WR_CW'(WR_CREDITS);
        end else begin
            if (xfer_start_i) begin
                beat_o <= '0;
            end else if (beat_advance_i || wr_take_i) begin
                beat_o <= beat_o + 1'b1;
            end
            case ({rd_take_i, rd_credit_i})
                2'b10:   rd_cnt <= rd_cnt - 1'b1;
                2'b01:   rd_cnt <= rd_cnt + 1'b1;
                default: rd_cnt <= rd_cnt;  // none or both
            endcase
            case ({wr_take_i, wr_credit_i})
                2'b10:   wr_cnt <= wr_cnt - 1'b1;
                2'b01:   wr_cnt <= wr_cnt + 1'b1;
                default: wr_cnt <= wr_cnt;
            endcase
        end
    end

    assign last_beat_o    = (beat_o == BEAT_W'(WORDS_PER_LINE - 1));
    assign rd_credit_ok_o = (rd_cnt != '0);
    assign wr_credit_ok_o = (wr_cnt != '0);

endmodule

`default_nettype wire

// ==== hdl/dcache_way_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_way_store #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - IDX_W
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [IDX_W-1:0]              rd_index_i,
    input  logic [dcache_pkg::BEAT_W-1:0] rd_word_i,
    input  logic [TAG_W-1:0]              lookup_tag_i,
    input  logic                          wr_en_i,
    input  logic                          wr_way_i,
    input  logic [IDX_W-1:0]              wr_index_i,
    input  logic [dcache_pkg::BEAT_W-1:0] wr_word_i,
    input  logic [dcache_pkg::DATA_W-1:0] wr_data_i,
    input  logic [dcache_pkg::STRB_W-1:0] wr_strb_i,
    input  logic                          tag_wr_en_i,
    input  logic [TAG_W-1:0]              tag_wr_i,
    input  logic                          victim_way_i,
    output logic                          hit_o,
    output logic                          hit_way_o,
    output logic [dcache_pkg::DATA_W-1:0] hit_word_o,
    output logic [TAG_W-1:0]              victim_tag_o,
    output logic [dcache_pkg::DATA_W-1:0] victim_word_o
);
    import dcache_pkg::*;

    localparam int DEPTH = NUM_SETS * WORDS_PER_LINE;

    logic [DATA_W-1:0]       word_q  [2];
    logic [TAG_W-1:0]        tag_q   [2];
    logic                    valid_q [2];
    logic [1:0]              way_hit;
    logic [IDX_W+BEAT_W-1:0] rd_addr;
    logic [IDX_W+BEAT_W-1:0] wr_addr;

    assign rd_addr = {rd_index_i, rd_word_i};
    assign wr_addr = {wr_index_i, wr_word_i};

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [DATA_W-1:0]   data_mem [DEPTH];
        logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
        logic [NUM_SETS-1:0] valid;

        always_ff @(posedge clk) begin
            if (wr_en_i && wr_way_i == 1'(w)) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wr_strb_i[b]) begin
                        data_mem[wr_addr][8*b +: 8] <= wr_data_i[8*b +: 8];
                    end
                end
            end
            if (tag_wr_en_i && wr_way_i == 1'(w)) begin
                tag_mem[wr_index_i] <= tag_wr_i;
            end
            word_q[w]  <= data_mem[rd_addr];  // read before write
            tag_q[w]   <= tag_mem[rd_index_i];
            valid_q[w] <= valid[rd_index_i];
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid <= '0;
            end else if (tag_wr_en_i && wr_way_i == 1'(w)) begin
                valid[wr_index_i] <= 1'b1;
            end
        end

        assign way_hit[w] = valid_q[w] && (tag_q[w] == lookup_tag_i);
    end

    assign hit_o         = |way_hit;
    assign hit_way_o     = way_hit[1];
    assign hit_word_o    = way_hit[1] ? word_q[1] : word_q[0];
    assign victim_tag_o  = tag_q[victim_way_i];
    assign victim_word_o = word_q[victim_way_i];

endmodule

`default_nettype wire

// ==== hdl/dcache_repl_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_repl_state #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [IDX_W-1:0] index_i,
    input  logic             touch_i,
    input  logic             touch_way_i,
    input  logic             set_dirty_i,
    input  logic             clean_i,
    input  logic             dirty_way_i,
    output logic             victim_way_o,
    output logic             victim_dirty_o
);

    logic [NUM_SETS-1:0]   lru;    // way to evict next
    logic [2*NUM_SETS-1:0] dirty;  // {set, way}

    always_ff @(posedge clk) begin
        if (reset) begin
            lru   <= '0;
            dirty <= '0;
        end else begin
            if (touch_i) begin
                lru[index_i] <= ~touch_way_i;
            end
            if (clean_i) begin
                dirty[{index_i, dirty_way_i}] <= 1'b0;
            end
            if (set_dirty_i) begin
                dirty[{index_i, dirty_way_i}] <= 1'b1;  // store on refill wins
            end
        end
    end

    assign victim_way_o   = lru[index_i];
    assign victim_dirty_o = dirty[{index_i, lru[index_i]}];

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - IDX_W
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid_i,
    input  dcache_pkg::cpu_op_e           req_op_i,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] req_wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0] req_wstrb_i,
    output logic                          req_ready_o,
    output logic                          rsp_valid_o,
    output logic [dcache_pkg::DATA_W-1:0] rsp_rdata_o,
    input  logic                          hit_i,
    input  logic                          hit_way_i,
    input  logic [dcache_pkg::DATA_W-1:0] hit_word_i,
    input  logic                          victim_way_i,
    input  logic                          victim_dirty_i,
    input  logic [TAG_W-1:0]              victim_tag_i,
    input  logic [dcache_pkg::DATA_W-1:0] victim_word_i,
    input  logic [dcache_pkg::BEAT_W-1:0] beat_i,
    input  logic                          last_beat_i,
    input  logic                          rd_credit_ok_i,
    input  logic                          wr_credit_ok_i,
    output logic                          xfer_start_o,
    output logic                          wr_beat_o,
    output logic                          rd_take_o,
    output logic                          mem_rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    input  logic                          mem_rdata_valid_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
    output logic                          mem_wr_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_wr_addr_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_wr_data_o,
    output logic [IDX_W-1:0]              arr_rd_index_o,
    output logic [dcache_pkg::BEAT_W-1:0] arr_rd_word_o,
    output logic                          arr_wr_en_o,
    output logic                          arr_wr_way_o,
    output logic [IDX_W-1:0]              arr_wr_index_o,
    output logic [dcache_pkg::BEAT_W-1:0] arr_wr_word_o,
    output logic [dcache_pkg::DATA_W-1:0] arr_wr_data_o,
    output logic [dcache_pkg::STRB_W-1:0] arr_wr_strb_o,
    output logic                          tag_wr_en_o,
    output logic [TAG_W-1:0]              tag_wr_o,
    output logic                          repl_touch_o,
    output logic                          repl_set_dirty_o,
    output logic                          repl_clean_o
);
    import dcache_pkg::*;

    ctrl_state_e       state;
    ctrl_state_e       next_state;
    cpu_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] merge_mask;
    logic [STRB_W-1:0] wstrb_q;
    logic [IDX_W-1:0]  idx_q;
    logic [BEAT_W-1:0] word_q;
    logic              accept;
    logic              lookup_hit;
    logic              is_store;

    assign idx_q      = addr_q[OFFSET_W +: IDX_W];
    assign word_q     = addr_q[OFFSET_W-1:2];
    assign is_store   = (op_q == OP_STORE);
    assign lookup_hit = (state == LOOKUP) && hit_i;
    assign accept     = req_valid_i && req_ready_o;

    // only a load hit can overlap with the next request
    assign req_ready_o = (state == IDLE) || (lookup_hit && !is_store);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            wstrb_q <= req_wstrb_i;
        end
        if (state == REFILL && mem_rdata_valid_i && beat_i == word_q) begin
            rdata_q <= mem_rdata_i;  // requested word
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    next_state = accept ? LOOKUP : IDLE;
                end else if (victim_dirty_i) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                if (wr_beat_o && last_beat_i) begin
                    next_state = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (mem_rd_req_o) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (mem_rdata_valid_i && last_beat_i) begin
                    next_state = FILL_DONE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assign xfer_start_o   = (state == LOOKUP && !hit_i && victim_dirty_i) || mem_rd_req_o;
    assign wr_beat_o      = (state == WRITEBACK) && wr_credit_ok_i;
    assign mem_wr_valid_o = wr_beat_o;
    assign mem_wr_addr_o  = {victim_tag_i, idx_q, OFFSET_W'(0)};
    assign mem_wr_data_o  = victim_word_i;
    assign mem_rd_req_o   = (state == REFILL_REQ) && rd_credit_ok_i;
    assign rd_take_o      = mem_rd_req_o;
    assign mem_rd_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};

    assign arr_rd_index_o = accept ? req_addr_i[OFFSET_W +: IDX_W] : idx_q;
    // read one beat ahead so the victim word is ready when its credit is
    assign arr_rd_word_o  = accept ? req_addr_i[OFFSET_W-1:2] :
                            (state == WRITEBACK) ? beat_i + BEAT_W'(wr_beat_o) : '0;

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            merge_mask[8*b +: 8] = {8{wstrb_q[b]}};
        end
    end

    assign arr_wr_en_o    = (lookup_hit && is_store) || (state == REFILL && mem_rdata_valid_i);
    assign arr_wr_way_o   = (state == LOOKUP) ? hit_way_i : victim_way_i;
    assign arr_wr_index_o = idx_q;
    assign arr_wr_word_o  = (state == LOOKUP) ? word_q : beat_i;
    assign arr_wr_strb_o  = (state == LOOKUP) ? wstrb_q : '1;

    always_comb begin
        arr_wr_data_o = mem_rdata_i;
        if (state == LOOKUP) begin
            arr_wr_data_o = wdata_q;
        end else if (is_store && beat_i == word_q) begin
            arr_wr_data_o = (wdata_q & merge_mask) | (mem_rdata_i & ~merge_mask);
        end
    end

    assign tag_wr_en_o      = (state == FILL_DONE);
    assign tag_wr_o         = addr_q[ADDR_W-1 -: TAG_W];
    assign repl_touch_o     = lookup_hit || (state == FILL_DONE);
    assign repl_set_dirty_o = is_store && (lookup_hit || state == FILL_DONE);
    assign repl_clean_o     = (state == FILL_DONE);

    assign rsp_valid_o = lookup_hit || (state == FILL_DONE);
    assign rsp_rdata_o = (state == LOOKUP) ? hit_word_i : rdata_q;

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter  int NUM_SETS   = 16,
    parameter  int WR_CREDITS = 4,
    parameter  int RD_CREDITS = 1,
    localparam int IDX_W      = $clog2(NUM_SETS),
    localparam int TAG_W      = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - IDX_W
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid_i,
    input  dcache_pkg::cpu_op_e           req_op_i,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] req_wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0] req_wstrb_i,
    output logic                          req_ready_o,
    output logic                          rsp_valid_o,
    output logic [dcache_pkg::DATA_W-1:0] rsp_rdata_o,
    output logic                          mem_rd_req_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr_o,
    input  logic                          mem_rd_credit_i,
    input  logic                          mem_rdata_valid_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
    output logic                          mem_wr_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_wr_addr_o,
    output logic [dcache_pkg::BEAT_W-1:0] mem_wr_beat_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_wr_data_o,
    input  logic                          mem_wr_credit_i
);
    import dcache_pkg::*;

    logic              hit, hit_way, victim_way, victim_dirty;
    logic [DATA_W-1:0] hit_word, victim_word, arr_wr_data;
    logic [TAG_W-1:0]  victim_tag, tag_wr;
    logic [BEAT_W-1:0] beat, arr_rd_word, arr_wr_word;
    logic              last_beat, rd_credit_ok, wr_credit_ok;
    logic              xfer_start, wr_beat, rd_take;
    logic [IDX_W-1:0]  arr_rd_index, arr_wr_index;
    logic              arr_wr_en, arr_wr_way, tag_wr_en;
    logic [STRB_W-1:0] arr_wr_strb;
    logic              repl_touch, repl_set_dirty, repl_clean;

    assign mem_wr_beat_o = beat;

    dcache_ctrl #(.NUM_SETS(NUM_SETS)) i_dcache_ctrl (
        .clk, .reset,
        .req_valid_i, .req_op_i, .req_addr_i, .req_wdata_i, .req_wstrb_i,
        .req_ready_o, .rsp_valid_o, .rsp_rdata_o,
        .hit_i(hit), .hit_way_i(hit_way), .hit_word_i(hit_word),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .victim_tag_i(victim_tag), .victim_word_i(victim_word),
        .beat_i(beat), .last_beat_i(last_beat),
        .rd_credit_ok_i(rd_credit_ok), .wr_credit_ok_i(wr_credit_ok),
        .xfer_start_o(xfer_start), .wr_beat_o(wr_beat), .rd_take_o(rd_take),
        .mem_rd_req_o, .mem_rd_addr_o, .mem_rdata_valid_i, .mem_rdata_i,
        .mem_wr_valid_o, .mem_wr_addr_o, .mem_wr_data_o,
        .arr_rd_index_o(arr_rd_index), .arr_rd_word_o(arr_rd_word),
        .arr_wr_en_o(arr_wr_en), .arr_wr_way_o(arr_wr_way),
        .arr_wr_index_o(arr_wr_index), .arr_wr_word_o(arr_wr_word),
        .arr_wr_data_o(arr_wr_data), .arr_wr_strb_o(arr_wr_strb),
        .tag_wr_en_o(tag_wr_en), .tag_wr_o(tag_wr),
        .repl_touch_o(repl_touch), .repl_set_dirty_o(repl_set_dirty),
        .repl_clean_o(repl_clean)
    );

    dcache_xfer_counter #(
        .RD_CREDITS(RD_CREDITS),
        .WR_CREDITS(WR_CREDITS)
    ) i_dcache_xfer_counter (
        .clk, .reset,
        .xfer_start_i(xfer_start), .beat_advance_i(mem_rdata_valid_i),
        .rd_take_i(rd_take), .rd_credit_i(mem_rd_credit_i),
        .wr_take_i(wr_beat), .wr_credit_i(mem_wr_credit_i),
        .beat_o(beat), .last_beat_o(last_beat),
        .rd_credit_ok_o(rd_credit_ok), .wr_credit_ok_o(wr_credit_ok)
    );

    dcache_way_store #(.NUM_SETS(NUM_SETS)) i_dcache_way_store (
        .clk, .reset,
        .rd_index_i(arr_rd_index), .rd_word_i(arr_rd_word),
        .lookup_tag_i(mem_rd_addr_o[ADDR_W-1 -: TAG_W]),  // tag of the held request
        .wr_en_i(arr_wr_en), .wr_way_i(arr_wr_way), .wr_index_i(arr_wr_index),
        .wr_word_i(arr_wr_word), .wr_data_i(arr_wr_data), .wr_strb_i(arr_wr_strb),
        .tag_wr_en_i(tag_wr_en), .tag_wr_i(tag_wr), .victim_way_i(victim_way),
        .hit_o(hit), .hit_way_o(hit_way), .hit_word_o(hit_word),
        .victim_tag_o(victim_tag), .victim_word_o(victim_word)
    );

    dcache_repl_state #(.NUM_SETS(NUM_SETS)) i_dcache_repl_state (
        .clk, .reset,
        .index_i(arr_wr_index),
        .touch_i(repl_touch), .touch_way_i(arr_wr_way),
        .set_dirty_i(repl_set_dirty), .clean_i(repl_clean), .dirty_way_i(arr_wr_way),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

    always #5 clk = ~clk;  // 10 ns period

endmodule

`default_nettype wire

// ==== bench/dcache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model #(
    parameter int MEM_WORDS = 4096
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         rd_req_i,
    input  wire  [31:0] rd_addr_i,
    output logic        rd_credit_o,
    output logic        rdata_valid_o,
    output logic [31:0] rdata_o,
    input  wire         wr_valid_i,
    input  wire  [31:0] wr_addr_i,
    input  wire  [2:0]  wr_beat_i,
    input  wire  [31:0] wr_data_i,
    output logic        wr_credit_o,
    input  wire         wr_stall_i
);

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] wb_addr [64];  // captured write-back beats
    logic [31:0] wb_data [64];
    int          wb_cnt;
    int          rd_req_cnt;
    int          wr_owed;

    initial begin
        void'($urandom(32'ha30e_ddb8));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom();
        end
        wb_cnt        = 0;
        rd_req_cnt    = 0;
        wr_owed       = 0;
        rd_credit_o   = 1'b0;
        rdata_valid_o = 1'b0;
        rdata_o       = '0;
        wr_credit_o   = 1'b0;
    end

    task automatic return_line(input logic [31:0] addr);
        int delay;
        delay = $urandom_range(4, 1);
        fork
            begin
                repeat (delay) @(posedge clk);
                #1 rd_credit_o = 1'b1;
                @(posedge clk);
                #1 rd_credit_o = 1'b0;
            end
            begin
                @(posedge clk);
                for (int b = 0; b < 8; b++) begin
                    #1;
                    rdata_valid_o = 1'b1;
                    rdata_o       = mem[addr[13:2] + b];
                    @(posedge clk);
                end
                #1 rdata_valid_o = 1'b0;
            end
        join
    endtask

    always @(negedge clk) begin
        if (!reset && rd_req_i) begin
            rd_req_cnt++;
            fork
                return_line(rd_addr_i);
            join_none
        end
        if (!reset && wr_valid_i) begin
            mem[wr_addr_i[13:2] + wr_beat_i] = wr_data_i;
            if (wb_cnt < 64) begin
                wb_addr[wb_cnt] = wr_addr_i + 32'(wr_beat_i) * 4;
                wb_data[wb_cnt] = wr_data_i;
            end
            wb_cnt++;
            wr_owed++;
        end
    end

    always @(posedge clk) begin
        #1;
        if (!wr_stall_i && wr_owed > 0) begin  // one credit per cycle
            wr_credit_o = 1'b1;
            wr_owed--;
        end else begin
            wr_credit_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    logic        clk;
    logic        reset;
    logic        req_valid;
    cpu_op_e     req_op;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;
    logic        req_ready_o;
    logic        rsp_valid_o;
    logic [31:0] rsp_rdata_o;
    logic        mem_rd_req_o;
    logic [31:0] mem_rd_addr_o;
    logic        mem_rd_credit;
    logic        mem_rdata_valid;
    logic [31:0] mem_rdata;
    logic        mem_wr_valid_o;
    logic [31:0] mem_wr_addr_o;
    logic [2:0]  mem_wr_beat_o;
    logic [31:0] mem_wr_data_o;
    logic        mem_wr_credit;
    logic        wr_stall;
    logic [31:0] ref_mem [4096];
    int          errors;
    int          checks;

    tb_clock i_tb_clock (.clk(clk), .reset(reset));

    dcache_top #(.NUM_SETS(16), .WR_CREDITS(4), .RD_CREDITS(1)) i_dcache_top (
        .clk, .reset,
        .req_valid_i(req_valid), .req_op_i(req_op), .req_addr_i(req_addr),
        .req_wdata_i(req_wdata), .req_wstrb_i(req_wstrb),
        .req_ready_o, .rsp_valid_o, .rsp_rdata_o,
        .mem_rd_req_o, .mem_rd_addr_o, .mem_rd_credit_i(mem_rd_credit),
        .mem_rdata_valid_i(mem_rdata_valid), .mem_rdata_i(mem_rdata),
        .mem_wr_valid_o, .mem_wr_addr_o, .mem_wr_beat_o, .mem_wr_data_o,
        .mem_wr_credit_i(mem_wr_credit)
    );

    dcache_mem_model i_mem (
        .clk, .reset,
        .rd_req_i(mem_rd_req_o), .rd_addr_i(mem_rd_addr_o), .rd_credit_o(mem_rd_credit),
        .rdata_valid_o(mem_rdata_valid), .rdata_o(mem_rdata),
        .wr_valid_i(mem_wr_valid_o), .wr_addr_i(mem_wr_addr_o), .wr_beat_i(mem_wr_beat_o),
        .wr_data_i(mem_wr_data_o), .wr_credit_o(mem_wr_credit), .wr_stall_i(wr_stall)
    );

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp, act);
        errors++;
        $display("ERROR %s expected %h actual %h", test, exp, act);
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic send_request(input cpu_op_e op, input logic [31:0] addr, wdata,
                                input logic [3:0] strb);
        int cyc;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        cyc = 0;
        @(negedge clk);
        while (!req_ready_o && cyc < 200) begin
            @(negedge clk);
            cyc++;
        end
        if (!req_ready_o) abort_run("request was never accepted");
        @(posedge clk);
        #1 req_valid = 1'b0;
        if (op == OP_STORE) begin
            ref_mem[addr[13:2]] = merge_bytes(ref_mem[addr[13:2]], wdata, strb);
        end
    endtask

    task automatic wait_response(output logic [31:0] rdata, output int lat);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!rsp_valid_o && lat < 1000);
        if (!rsp_valid_o) abort_run("no response from the cache");
        rdata = rsp_rdata_o;
    endtask

    // load and compare with the reference image
    task automatic load_check(input string test, input logic [31:0] addr, output int lat);
        logic [31:0] data;
        send_request(OP_LOAD, addr, '0, '0);
        wait_response(data, lat);
        checks++;
        if (data !== ref_mem[addr[13:2]]) report_mismatch(test, ref_mem[addr[13:2]], data);
    endtask

    task automatic store_word(input logic [31:0] addr, wdata, input logic [3:0] strb);
        logic [31:0] data;
        int          lat;
        send_request(OP_STORE, addr, wdata, strb);
        wait_response(data, lat);
    endtask

    task automatic check_writeback(input string test, input logic [31:0] line, input int base);
        for (int j = 0; j < 8; j++) begin
            checks += 2;
            if (i_mem.wb_addr[base+j] !== line + 4*j) begin
                report_mismatch(test, line + 4*j, i_mem.wb_addr[base+j]);
            end
            if (i_mem.wb_data[base+j] !== ref_mem[line[13:2] + j]) begin
                report_mismatch(test, ref_mem[line[13:2] + j], i_mem.wb_data[base+j]);
            end
        end
    endtask

    task automatic reset_and_fill();
        int rd0;
        int lat;
        checks += 4;
        if (req_ready_o !== 1'b1) report_mismatch("reset", 1, req_ready_o);
        if (rsp_valid_o !== 1'b0) report_mismatch("reset", 0, rsp_valid_o);
        if (mem_rd_req_o !== 1'b0) report_mismatch("reset", 0, mem_rd_req_o);
        if (mem_wr_valid_o !== 1'b0) report_mismatch("reset", 0, mem_wr_valid_o);
        rd0 = i_mem.rd_req_cnt;
        load_check("first_load", 32'h0000_0104, lat);
        checks += 3;
        if (i_mem.rd_req_cnt != rd0 + 1) begin
            report_mismatch("first_load", rd0 + 1, i_mem.rd_req_cnt);
        end
        load_check("repeat_load", 32'h0000_0110, lat);
        if (i_mem.rd_req_cnt != rd0 + 1) begin
            report_mismatch("repeat_load", rd0 + 1, i_mem.rd_req_cnt);
        end
        if (lat != 1) report_mismatch("repeat_load_latency", 1, lat);
    endtask

    task automatic store_merge();
        int lat;
        store_word(32'h0000_0108, 32'ha5a5_5a5a, 4'b0101);  // hit
        load_check("store_hit_merge", 32'h0000_0108, lat);
        store_word(32'h0000_0244, 32'h1234_5678, 4'b1010);  // miss, merged in refill
        load_check("store_miss_merge", 32'h0000_0244, lat);
    endtask

    task automatic lru_replacement();
        int rd0;
        int lat;
        load_check("lru_a", 32'h0000_0060, lat);
        load_check("lru_b", 32'h0000_0260, lat);
        load_check("lru_a2", 32'h0000_0064, lat);
        load_check("lru_c", 32'h0000_0460, lat);
        rd0 = i_mem.rd_req_cnt;
        load_check("lru_a3", 32'h0000_0068, lat);
        checks += 2;
        if (i_mem.rd_req_cnt != rd0) report_mismatch("lru_a_kept", rd0, i_mem.rd_req_cnt);
        load_check("lru_b2", 32'h0000_0264, lat);
        if (i_mem.rd_req_cnt != rd0 + 1) begin
            report_mismatch("lru_b_evicted", rd0 + 1, i_mem.rd_req_cnt);
        end
    endtask

    task automatic dirty_eviction();
        int wb0;
        int lat;
        store_word(32'h0000_00a4, 32'hdead_beef, 4'b1111);
        load_check("evict_fill", 32'h0000_02a0, lat);
        wb0 = i_mem.wb_cnt;
        load_check("evict_dirty", 32'h0000_04a0, lat);
        checks++;
        if (i_mem.wb_cnt != wb0 + 8) report_mismatch("evict_dirty_beats", wb0 + 8, i_mem.wb_cnt);
        check_writeback("evict_dirty_data", 32'h0000_00a0, wb0);
        wb0 = i_mem.wb_cnt;
        load_check("evict_clean", 32'h0000_06a0, lat);
        checks++;
        if (i_mem.wb_cnt != wb0) report_mismatch("evict_clean_beats", wb0, i_mem.wb_cnt);
    endtask

    task automatic credit_stall();
        logic [31:0] data;
        int          wb0;
        int          seen;
        int          cyc;
        int          lat;
        store_word(32'h0000_00c8, 32'h0bad_cafe, 4'b1100);
        load_check("stall_fill", 32'h0000_02c0, lat);
        cyc = 0;
        while ((i_mem.wr_owed != 0 || mem_wr_credit) && cyc < 100) begin
            @(negedge clk);
            cyc++;
        end
        if (i_mem.wr_owed != 0 || mem_wr_credit) abort_run("write credits never came back");
        wr_stall = 1'b1;
        wb0 = i_mem.wb_cnt;
        send_request(OP_LOAD, 32'h0000_04c4, '0, '0);
        seen = 0;
        cyc  = 0;
        while (seen < 4 && cyc < 200) begin
            @(negedge clk);
            cyc++;
            if (mem_wr_valid_o) begin
                seen++;
            end
        end
        if (seen < 4) abort_run("first write-back beats never came");
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (mem_wr_valid_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
                errors++;
                $display("ERROR stall: write beat or response seen while credits are held");
            end
        end
        wr_stall = 1'b0;
        wait_response(data, lat);
        checks += 2;
        if (data !== ref_mem[32'h04c4 >> 2]) begin
            report_mismatch("stall_load", ref_mem[32'h04c4 >> 2], data);
        end
        if (i_mem.wb_cnt != wb0 + 8) report_mismatch("stall_beats", wb0 + 8, i_mem.wb_cnt);
        check_writeback("stall_data", 32'h0000_00c0, wb0);
    endtask

    task automatic back_to_back_hits();
        logic [31:0] addrs [8];
        int          acc_cyc [8];
        int          n_acc;
        int          n_rsp;
        int          cyc;
        for (int k = 0; k < 8; k++) begin
            addrs[k] = 32'h0000_0100 + 4*k;
        end
        n_acc = 0;
        n_rsp = 0;
        cyc   = 0;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_op    = OP_LOAD;
        req_addr  = addrs[0];
        while (n_rsp < 8 && cyc < 100) begin
            @(negedge clk);
            cyc++;
            if (rsp_valid_o) begin
                checks += 2;
                if (rsp_rdata_o !== ref_mem[addrs[n_rsp][13:2]]) begin
                    report_mismatch("b2b_data", ref_mem[addrs[n_rsp][13:2]], rsp_rdata_o);
                end
                if (cyc != acc_cyc[n_rsp] + 1) begin
                    report_mismatch("b2b_latency", 1, cyc - acc_cyc[n_rsp]);
                end
                n_rsp++;
            end
            if (req_valid && req_ready_o) begin
                acc_cyc[n_acc] = cyc;
                n_acc++;
            end
            @(posedge clk);
            #1;
            if (n_acc < 8) begin
                req_addr = addrs[n_acc];
            end else begin
                req_valid = 1'b0;
            end
        end
        if (n_rsp < 8) abort_run("back-to-back responses stopped");
        checks++;
        if (acc_cyc[7] != acc_cyc[0] + 7) report_mismatch("b2b_rate", 7, acc_cyc[7] - acc_cyc[0]);
    endtask

    initial begin
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        wr_stall  = 1'b0;
        errors    = 0;
        checks    = 0;
        @(negedge reset);
        for (int i = 0; i < 4096; i++) ref_mem[i] = i_mem.mem[i];
        @(negedge clk);
        reset_and_fill();
        store_merge();
        lru_replacement();
        dirty_eviction();
        credit_stall();
        back_to_back_hits();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
hdl/dcache_pkg.sv
hdl/dcache_xfer_counter.sv
hdl/dcache_way_store.sv
hdl/dcache_repl_state.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/tb_clock.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_xfer_counter.sv
  - hdl/dcache_way_store.sv
  - hdl/dcache_repl_state.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/dcache_mem_model.sv
      - bench/dcache_tb.sv
